/* logic/controlEncoder.sv */
`timescale 1ns/1ns

module controlEncoder (
	input  logic                     clk,
	input  logic                     reset,
	input  controlPkg::ctrlState_t   state,
	input  controlPkg::excCause_t    cause,
	input  controlPkg::opClass_t     opClass,
	output controlPkg::controlWord_t ctrl
);
	import controlPkg::*;

	controlWord_t nextCtrl;
	logic         immOp;

	function automatic aluOp_t execAluOp(opClass_t cls);
		case (cls)
			clsSubRegChecked:
				return aluSub;
			clsAluReg:
				return aluAnd;
			clsSetLess:
				return aluCompare;
			default:
				return aluAdd;
		endcase
	endfunction

	function automatic regDst_t destFor(opClass_t cls);
		case (cls)
			clsAluReg, clsAluRegChecked, clsSubRegChecked, clsSetLess:
				return dstRd;
			default:
				return dstRt;
		endcase
	endfunction

	assign immOp = (opClass == clsAluImm) || (opClass == clsAluImmChecked);

	always_comb begin
		nextCtrl = '0;
		case (state)
			stReset:
				nextCtrl.clearRegs = 1'b1;
			// pc <= pc + 4 while memory reads the instruction
			stFetch: begin
				nextCtrl.pcWrite = 1'b1;
				nextCtrl.addrSrc = addrPc;
				nextCtrl.aluSrcA = srcAPc;
				nextCtrl.aluSrcB = srcBFour;
				nextCtrl.aluOp = aluAdd;
				nextCtrl.pcSrc = pcAluResult;
			end
			stIrLoad:
				nextCtrl.irWrite = 1'b1;
			// branch target parked in aluOut
			stDecode: begin
				nextCtrl.loadAB = 1'b1;
				nextCtrl.aluOutWrite = 1'b1;
				nextCtrl.aluSrcA = srcAPc;
				nextCtrl.aluSrcB = srcBBranchOffset;
				nextCtrl.aluOp = aluAdd;
			end
			stAluExec, stOverflowCheck: begin
				nextCtrl.aluOutWrite = (state == stAluExec);
				nextCtrl.aluSrcA = srcARegA;
				nextCtrl.aluSrcB = immOp ? srcBSignExt : srcBRegB;
				nextCtrl.aluOp = execAluOp(opClass);
			end
			stWriteBack: begin
				nextCtrl.regWrite = 1'b1;
				nextCtrl.regDst = destFor(opClass);
				// slt keeps the compare running for the less-than flag
				if (opClass == clsSetLess) begin
					nextCtrl.wbSrc = wbLessThan;
					nextCtrl.aluSrcA = srcARegA;
					nextCtrl.aluSrcB = srcBRegB;
					nextCtrl.aluOp = aluCompare;
				end else begin
					nextCtrl.wbSrc = wbAluOut;
				end
			end
			stAddrCalc, stMemWrite: begin
				nextCtrl.aluOutWrite = (state == stAddrCalc);
				nextCtrl.memWrite = (state == stMemWrite);
				nextCtrl.addrSrc = (state == stMemWrite) ? addrAluOut : addrPc;
				nextCtrl.aluSrcA = srcARegA;
				nextCtrl.aluSrcB = srcBSignExt;
				nextCtrl.aluOp = aluAdd;
			end
			stMemRead:
				nextCtrl.addrSrc = addrAluOut;
			stMemReadWait: begin
				nextCtrl.addrSrc = addrAluOut;
				nextCtrl.mdrWrite = 1'b1;
			end
			stLoadWrite: begin
				nextCtrl.regWrite = 1'b1;
				nextCtrl.regDst = dstRt;
				nextCtrl.wbSrc = wbMdr;
			end
			stBranchCompare: begin
				nextCtrl.aluSrcA = srcARegA;
				nextCtrl.aluSrcB = srcBRegB;
				nextCtrl.aluOp = aluSub;
			end
			stBranchTake: begin
				nextCtrl.pcWrite = 1'b1;
				nextCtrl.pcSrc = pcAluOut;
			end
			// jal links the already incremented pc
			stJumpExec: begin
				nextCtrl.pcWrite = 1'b1;
				nextCtrl.pcSrc = pcJumpTarget;
				nextCtrl.regWrite = (opClass == clsJumpLink);
				nextCtrl.regDst = dstRa;
				nextCtrl.wbSrc = wbPc;
			end
			stMultStart:
				nextCtrl.multStart = 1'b1;
			stDivStart:
				nextCtrl.divStart = 1'b1;
			stMultWrite, stDivWrite: begin
				nextCtrl.hiLoWrite = 1'b1;
				nextCtrl.hiLoSrc = (state == stDivWrite) ? hiLoDiv : hiLoMult;
			end
			// epc gets pc - 4, the faulting instruction
			stExcEntry: begin
				nextCtrl.epcWrite = 1'b1;
				nextCtrl.cause = cause;
				nextCtrl.aluSrcA = srcAPc;
				nextCtrl.aluSrcB = srcBFour;
				nextCtrl.aluOp = aluSub;
			end
			stExcWait: begin
				nextCtrl.addrSrc = addrVector;
				nextCtrl.cause = cause;
			end
			stExcVector: begin
				nextCtrl.pcWrite = 1'b1;
				nextCtrl.pcSrc = pcVector;
				nextCtrl.addrSrc = addrVector;
				nextCtrl.cause = cause;
			end
			default:
				nextCtrl.aluOp = aluPass;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl <= nextCtrl;
		end
	end

endmodule

/* logic/controlPkg.sv */
package controlPkg;

	// primary opcodes
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opAddiu = 6'h09,
		opLw    = 6'h23,
		opSw    = 6'h2B
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0] {
		fnMult = 6'h18,
		fnDiv  = 6'h1A,
		fnAdd  = 6'h20,
		fnSub  = 6'h22,
		fnAnd  = 6'h24,
		fnSlt  = 6'h2A
	} funct_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFields_t;

	// same 32 bits, read as R or I format
	typedef union packed {
		rFields_t r;
		iFields_t i;
	} instrWord_t;

	// sub gets its own class so the ALU op can be chosen from the class alone
	typedef enum logic [3:0] {
		clsAluReg,
		clsAluRegChecked,
		clsSubRegChecked,
		clsAluImm,
		clsAluImmChecked,
		clsSetLess,
		clsBranchEq,
		clsBranchNe,
		clsLoadWord,
		clsStoreWord,
		clsJump,
		clsJumpLink,
		clsMultiply,
		clsDivide,
		clsUndefined
	} opClass_t;

	typedef enum logic [4:0] {
		stReset,
		stFetch,
		stMemWait,
		stIrLoad,
		stDecode,
		stAluExec,
		stOverflowCheck,
		stWriteBack,
		stAddrCalc,
		stMemRead,
		stMemReadWait,
		stLoadWrite,
		stMemWrite,
		stBranchCompare,
		stBranchTake,
		stJumpExec,
		stMultStart,
		stMultWait,
		stMultWrite,
		stDivStart,
		stDivWait,
		stDivWrite,
		stExcEntry,
		stExcWait,
		stExcVector
	} ctrlState_t;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluCompare
	} aluOp_t;

	typedef enum logic [1:0] {addrPc, addrAluOut, addrVector} addrSrc_t;
	typedef enum logic [1:0] {srcAPc, srcARegA} aluSrcA_t;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBSignExt, srcBBranchOffset} aluSrcB_t;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDst_t;
	typedef enum logic [1:0] {wbAluOut, wbMdr, wbPc, wbLessThan} wbSrc_t;
	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget, pcVector} pcSrc_t;
	typedef enum logic {hiLoMult, hiLoDiv} hiLoSrc_t;
	typedef enum logic [1:0] {causeNone, causeUndefined, causeOverflow, causeDivZero} excCause_t;

	// flags coming back from the datapath
	typedef struct packed {
		logic overflow;
		logic equal;
		logic lessThan;
		logic multDone;
		logic divDone;
		logic divZero;
	} dpStatus_t;

	typedef struct packed {
		logic      clearRegs;
		logic      pcWrite;
		logic      irWrite;
		logic      memWrite;
		logic      regWrite;
		logic      loadAB;
		logic      aluOutWrite;
		logic      mdrWrite;
		logic      epcWrite;
		logic      hiLoWrite;
		logic      multStart;
		logic      divStart;
		addrSrc_t  addrSrc;
		aluSrcA_t  aluSrcA;
		aluSrcB_t  aluSrcB;
		aluOp_t    aluOp;
		regDst_t   regDst;
		wbSrc_t    wbSrc;
		pcSrc_t    pcSrc;
		hiLoSrc_t  hiLoSrc;
		excCause_t cause;
	} controlWord_t;

endpackage

/* logic/controlSequencer.sv */
`timescale 1ns/1ns

module controlSequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  controlPkg::opClass_t   opClass,
	input  controlPkg::dpStatus_t  status,
	output controlPkg::ctrlState_t state,
	output controlPkg::excCause_t  cause
);
	import controlPkg::*;

	ctrlState_t nextState;
	excCause_t  nextCause;
	logic       checkedOp;
	logic       branchTaken;

	// add, sub and addi trap on overflow
	assign checkedOp = (opClass == clsAluRegChecked) || (opClass == clsSubRegChecked) ||
		(opClass == clsAluImmChecked);

	assign branchTaken = (opClass == clsBranchEq) ? status.equal : !status.equal;

	always_comb begin
		nextState = state;
		nextCause = causeNone;
		case (state)
			stReset:
				nextState = stFetch;
			stFetch:
				nextState = stMemWait;
			stMemWait:
				nextState = stIrLoad;
			stIrLoad:
				nextState = stDecode;
			stDecode: begin
				case (opClass)
					clsAluReg, clsAluRegChecked, clsSubRegChecked,
					clsAluImm, clsAluImmChecked, clsSetLess:
						nextState = stAluExec;
					clsBranchEq, clsBranchNe:
						nextState = stBranchCompare;
					clsLoadWord, clsStoreWord:
						nextState = stAddrCalc;
					clsJump, clsJumpLink:
						nextState = stJumpExec;
					clsMultiply:
						nextState = stMultStart;
					clsDivide:
						nextState = stDivStart;
					default: begin
						nextState = stExcEntry;
						nextCause = causeUndefined;
					end
				endcase
			end
			stAluExec: begin
				if (checkedOp) begin
					nextState = stOverflowCheck;
				end else begin
					nextState = stWriteBack;
				end
			end
			stOverflowCheck: begin
				if (status.overflow) begin
					nextState = stExcEntry;
					nextCause = causeOverflow;
				end else begin
					nextState = stWriteBack;
				end
			end
			stWriteBack:
				nextState = stFetch;
			stAddrCalc: begin
				if (opClass == clsLoadWord) begin
					nextState = stMemRead;
				end else begin
					nextState = stMemWrite;
				end
			end
			stMemRead:
				nextState = stMemReadWait;
			stMemReadWait:
				nextState = stLoadWrite;
			stLoadWrite:
				nextState = stFetch;
			stMemWrite:
				nextState = stFetch;
			stBranchCompare: begin
				if (branchTaken) begin
					nextState = stBranchTake;
				end else begin
					nextState = stFetch;
				end
			end
			stBranchTake:
				nextState = stFetch;
			stJumpExec:
				nextState = stFetch;
			stMultStart:
				nextState = stMultWait;
			// hold here until the multiplier answers
			stMultWait: begin
				if (status.multDone) begin
					nextState = stMultWrite;
				end
			end
			stMultWrite:
				nextState = stFetch;
			stDivStart:
				nextState = stDivWait;
			// divide by zero wins over done
			stDivWait: begin
				if (status.divZero) begin
					nextState = stExcEntry;
					nextCause = causeDivZero;
				end else if (status.divDone) begin
					nextState = stDivWrite;
				end
			end
			stDivWrite:
				nextState = stFetch;
			stExcEntry:
				nextState = stExcWait;
			stExcWait:
				nextState = stExcVector;
			stExcVector:
				nextState = stFetch;
			default:
				nextState = stFetch;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stReset;
			cause <= causeNone;
		end else begin
			state <= nextState;
			// cause only changes on the way into excEntry
			if (nextState == stExcEntry) begin
				cause <= nextCause;
			end
		end
	end

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
	input  logic                     clk,
	input  logic                     reset,
	input  controlPkg::instrWord_t   instr,
	input  controlPkg::dpStatus_t    status,
	output controlPkg::controlWord_t ctrl
);
	import controlPkg::*;

	opClass_t   opClass;
	ctrlState_t state;
	excCause_t  cause;

	// decode, then sequence, then the registered control word
	instrDecoder instrDecoder_inst (
		.instr   (instr),
		.opClass (opClass)
	);

	controlSequencer controlSequencer_inst (
		.clk     (clk),
		.reset   (reset),
		.opClass (opClass),
		.status  (status),
		.state   (state),
		.cause   (cause)
	);

	controlEncoder controlEncoder_inst (
		.clk     (clk),
		.reset   (reset),
		.state   (state),
		.cause   (cause),
		.opClass (opClass),
		.ctrl    (ctrl)
	);

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder (
	input  controlPkg::instrWord_t instr,
	output controlPkg::opClass_t   opClass
);
	import controlPkg::*;

	opClass_t rClass;

	// R-type classes come from the function field only
	always_comb begin
		case (instr.r.funct)
			fnAdd:
				rClass = clsAluRegChecked;
			fnSub:
				rClass = clsSubRegChecked;
			fnAnd:
				rClass = clsAluReg;
			fnSlt:
				rClass = clsSetLess;
			fnMult:
				rClass = clsMultiply;
			fnDiv:
				rClass = clsDivide;
			default:
				rClass = clsUndefined;
		endcase
	end

	always_comb begin
		case (instr.i.opcode)
			opRType:
				opClass = rClass;
			opAddi:
				opClass = clsAluImmChecked;
			opAddiu:
				opClass = clsAluImm;
			opBeq:
				opClass = clsBranchEq;
			opBne:
				opClass = clsBranchNe;
			opLw:
				opClass = clsLoadWord;
			opSw:
				opClass = clsStoreWord;
			opJ:
				opClass = clsJump;
			opJal:
				opClass = clsJumpLink;
			// anything else traps as undefined
			default:
				opClass = clsUndefined;
		endcase
	end

endmodule

/* mipsControl.f */
logic/controlPkg.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/controlEncoder.sv
logic/controlUnit.sv
testbench/controlUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module controlUnitTb \
	-f mipsControl.f -o controlUnitSim \
	&& ./obj_dir/controlUnitSim | tee /dev/stderr | grep -q "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/controlUnitTb.sv */
`timescale 1ns/1ns

module controlUnitTb;
	import controlPkg::*;

	typedef struct packed {
		logic [31:0] word;
		logic        overflow;
		logic        equal;
		logic        divZero;
	} testCase_t;

	localparam int numTests = 24;
	localparam int timeoutCycles = 40 * numTests + 20;

	logic         clk = 1'b0;
	logic         reset = 1'b1;
	instrWord_t   instr = '0;
	dpStatus_t    status;
	controlWord_t ctrl;
	logic         overflowFlag = 1'b0;
	logic         equalFlag = 1'b0;
	logic         multDoneFlag = 1'b0;
	logic         divDoneFlag = 1'b0;
	logic         divZeroFlag = 1'b0;
	logic         zeroDivisor = 1'b0;
	logic         anyStrobe;
	logic         isFetch;
	testCase_t    tests [numTests];
	integer       seed = 67064;
	int           waitCycles = 0;
	logic         divPending = 1'b0;
	int           cycleCount = 0;
	int           issued = 0;
	logic         allDone = 1'b0;
	logic         firstFetch = 1'b0;
	logic         irSeen = 1'b0;
	logic         unitBusy = 1'b0;
	logic         doneSeen = 1'b0;
	int           clearCount = 0;
	int           irCount;
	int           regCount;
	int           memCount;
	int           mdrCount;
	int           epcCount;
	int           pcCount;
	int           hiLoCount;
	int           multCount;
	int           divCount;
	int           expReg;
	int           expMem;
	int           expMdr;
	int           expEpc;
	int           expPc;
	int           expHiLo;
	int           expMult;
	int           expDiv;
	regDst_t      expDst;
	wbSrc_t       expWb;
	pcSrc_t       expPcSrc;
	hiLoSrc_t     expHiLoSrc;
	excCause_t    expCause;

	controlUnit controlUnit_inst (
		.clk    (clk),
		.reset  (reset),
		.instr  (instr),
		.status (status),
		.ctrl   (ctrl)
	);

	always #2 clk = ~clk;

	assign status = '{overflow: overflowFlag, equal: equalFlag, lessThan: 1'b0,
		multDone: multDoneFlag, divDone: divDoneFlag, divZero: divZeroFlag};
	assign anyStrobe = ctrl.clearRegs | ctrl.pcWrite | ctrl.irWrite | ctrl.memWrite |
		ctrl.regWrite | ctrl.loadAB | ctrl.aluOutWrite | ctrl.mdrWrite | ctrl.epcWrite |
		ctrl.hiLoWrite | ctrl.multStart | ctrl.divStart;
	// pc + 4 is the only pc write that uses the ALU result directly
	assign isFetch = ctrl.pcWrite && (ctrl.pcSrc == pcAluResult);

	function automatic logic [31:0] rWord(input logic [5:0] funct);
		return {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] opcode);
		return {opcode, 5'd4, 5'd5, 16'h0010};
	endfunction

	function automatic testCase_t makeCase(input logic [31:0] word, input logic ovf,
		input logic eq, input logic zero);
		return '{word: word, overflow: ovf, equal: eq, divZero: zero};
	endfunction

	task automatic failValue(input string name, input int expected, input int actual);
		$display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "wrong control value");
	endtask

	task automatic failEvent(input string what);
		$display("%0t ns: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "wrong control sequence");
	endtask

	task automatic expectTrap(input excCause_t c);
		expEpc = 1;
		expCause = c;
		expPc = 1;
		expPcSrc = pcVector;
	endtask

	task automatic expectWrite(input regDst_t dst, input wbSrc_t wb);
		expReg = 1;
		expDst = dst;
		expWb = wb;
	endtask

	// expected strobe counts and fields for one instruction
	task automatic loadExpectations(input testCase_t tc);
		expReg = 0;
		expMem = 0;
		expMdr = 0;
		expEpc = 0;
		expPc = 0;
		expHiLo = 0;
		expMult = 0;
		expDiv = 0;
		expDst = dstRt;
		expWb = wbAluOut;
		expPcSrc = pcAluOut;
		expHiLoSrc = hiLoMult;
		expCause = causeNone;
		if (tc.word[31:26] == opRType) begin
			case (tc.word[5:0])
				fnAdd, fnSub:
					if (tc.overflow) expectTrap(causeOverflow);
					else expectWrite(dstRd, wbAluOut);
				fnAnd:
					expectWrite(dstRd, wbAluOut);
				fnSlt:
					expectWrite(dstRd, wbLessThan);
				fnMult: begin
					expMult = 1;
					expHiLo = 1;
				end
				fnDiv: begin
					expDiv = 1;
					expHiLoSrc = hiLoDiv;
					if (tc.divZero) expectTrap(causeDivZero);
					else expHiLo = 1;
				end
				default:
					expectTrap(causeUndefined);
			endcase
		end else begin
			case (tc.word[31:26])
				opAddi:
					if (tc.overflow) expectTrap(causeOverflow);
					else expectWrite(dstRt, wbAluOut);
				opAddiu:
					expectWrite(dstRt, wbAluOut);
				opBeq:
					expPc = tc.equal ? 1 : 0;
				opBne:
					expPc = tc.equal ? 0 : 1;
				opLw: begin
					expectWrite(dstRt, wbMdr);
					expMdr = 1;
				end
				opSw:
					expMem = 1;
				opJ: begin
					expPc = 1;
					expPcSrc = pcJumpTarget;
				end
				opJal: begin
					expPc = 1;
					expPcSrc = pcJumpTarget;
					expectWrite(dstRa, wbPc);
				end
				default:
					expectTrap(causeUndefined);
			endcase
		end
	endtask

	task automatic closeInstruction();
		assert (irCount == 1) else failValue("irWrite count", 1, irCount);
		assert (regCount == expReg) else failValue("regWrite count", expReg, regCount);
		assert (memCount == expMem) else failValue("memWrite count", expMem, memCount);
		assert (mdrCount == expMdr) else failValue("mdrWrite count", expMdr, mdrCount);
		assert (epcCount == expEpc) else failValue("epcWrite count", expEpc, epcCount);
		assert (pcCount == expPc) else failValue("extra pcWrite count", expPc, pcCount);
		assert (hiLoCount == expHiLo) else failValue("hiLoWrite count", expHiLo, hiLoCount);
		assert (multCount == expMult) else failValue("multStart count", expMult, multCount);
		assert (divCount == expDiv) else failValue("divStart count", expDiv, divCount);
	endtask

	// checks every strobe and issues the next instruction at each fetch
	always @(posedge clk) begin
		if (!reset) begin
			if (ctrl.clearRegs) begin
				assert (clearCount == 0 && !firstFetch)
					else failEvent("clearRegs repeated or late");
				clearCount++;
			end
			if (!irSeen) begin
				assert (!ctrl.memWrite && !ctrl.regWrite)
					else failEvent("memory or register write before the first irWrite");
			end
			if (unitBusy) begin
				assert (!anyStrobe) else failEvent("strobe active while waiting on mult or div");
			end
			if (status.multDone || status.divDone || status.divZero) unitBusy = 1'b0;
			if (status.multDone || status.divDone) doneSeen = 1'b1;
			if (ctrl.irWrite) begin
				irSeen = 1'b1;
				irCount++;
			end
			if (ctrl.regWrite) begin
				regCount++;
				assert (ctrl.regDst == expDst)
					else failValue("ctrl.regDst", int'(expDst), int'(ctrl.regDst));
				assert (ctrl.wbSrc == expWb)
					else failValue("ctrl.wbSrc", int'(expWb), int'(ctrl.wbSrc));
				if (expWb == wbMdr) begin
					assert (mdrCount == 1) else failValue("mdrWrite before load", 1, mdrCount);
				end
			end
			if (ctrl.memWrite) begin
				memCount++;
				assert (ctrl.addrSrc == addrAluOut)
					else failValue("ctrl.addrSrc", int'(addrAluOut), int'(ctrl.addrSrc));
				assert (ctrl.aluSrcB == srcBSignExt)
					else failValue("ctrl.aluSrcB", int'(srcBSignExt), int'(ctrl.aluSrcB));
			end
			if (ctrl.mdrWrite) mdrCount++;
			if (ctrl.epcWrite) begin
				epcCount++;
				assert (ctrl.cause == expCause)
					else failValue("ctrl.cause", int'(expCause), int'(ctrl.cause));
			end
			if (ctrl.pcWrite && !isFetch) begin
				pcCount++;
				assert (ctrl.pcSrc == expPcSrc)
					else failValue("ctrl.pcSrc", int'(expPcSrc), int'(ctrl.pcSrc));
				if (expPcSrc == pcVector) begin
					assert (epcCount == 1) else failValue("epcWrite before vector", 1, epcCount);
				end
			end
			if (ctrl.hiLoWrite) begin
				hiLoCount++;
				assert (doneSeen) else failEvent("hiLoWrite before the unit reported done");
				assert (ctrl.hiLoSrc == expHiLoSrc)
					else failValue("ctrl.hiLoSrc", int'(expHiLoSrc), int'(ctrl.hiLoSrc));
			end
			if (ctrl.multStart) multCount++;
			if (ctrl.divStart) divCount++;
			if (ctrl.multStart || ctrl.divStart) unitBusy = 1'b1;
			if (isFetch) begin
				// fetch reads memory at pc and adds four to it
				assert (ctrl.addrSrc == addrPc)
					else failValue("ctrl.addrSrc", int'(addrPc), int'(ctrl.addrSrc));
				assert (ctrl.aluSrcA == srcAPc)
					else failValue("ctrl.aluSrcA", int'(srcAPc), int'(ctrl.aluSrcA));
				assert (ctrl.aluSrcB == srcBFour)
					else failValue("ctrl.aluSrcB", int'(srcBFour), int'(ctrl.aluSrcB));
				assert (ctrl.aluOp == aluAdd)
					else failValue("ctrl.aluOp", int'(aluAdd), int'(ctrl.aluOp));
				if (!firstFetch) begin
					assert (clearCount == 1) else failValue("clearRegs count", 1, clearCount);
				end
				firstFetch = 1'b1;
				if (issued > 0) closeInstruction();
				if (issued < numTests) begin
					instr <= tests[issued].word;
					overflowFlag <= tests[issued].overflow;
					equalFlag <= tests[issued].equal;
					zeroDivisor <= tests[issued].divZero;
					loadExpectations(tests[issued]);
					irCount = 0;
					regCount = 0;
					memCount = 0;
					mdrCount = 0;
					epcCount = 0;
					pcCount = 0;
					hiLoCount = 0;
					multCount = 0;
					divCount = 0;
					doneSeen = 1'b0;
					issued++;
				end else begin
					allDone = 1'b1;
				end
			end
		end
	end

	// mult/div unit answers a start pulse after 1 to 8 cycles
	always @(posedge clk) begin
		multDoneFlag <= 1'b0;
		divDoneFlag <= 1'b0;
		divZeroFlag <= 1'b0;
		if (!reset) begin
			if (ctrl.multStart || ctrl.divStart) begin
				waitCycles <= 1 + ($unsigned($random(seed)) % 8);
				divPending <= ctrl.divStart;
			end else if (waitCycles == 1) begin
				if (divPending && zeroDivisor) divZeroFlag <= 1'b1;
				else if (divPending) divDoneFlag <= 1'b1;
				else multDoneFlag <= 1'b1;
				waitCycles <= 0;
			end else if (waitCycles > 1) begin
				waitCycles <= waitCycles - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > timeoutCycles) begin
			$display("timeout after %0d cycles without reaching fetch", cycleCount);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	initial begin
		tests[0] = makeCase(rWord(fnAdd), 1'b0, 1'b0, 1'b0);
		tests[1] = makeCase(rWord(fnAdd), 1'b1, 1'b0, 1'b0);
		tests[2] = makeCase(rWord(fnSub), 1'b0, 1'b1, 1'b0);
		tests[3] = makeCase(rWord(fnSub), 1'b1, 1'b0, 1'b0);
		// and ignores the overflow flag
		tests[4] = makeCase(rWord(fnAnd), 1'b1, 1'b0, 1'b0);
		tests[5] = makeCase(rWord(fnSlt), 1'b0, 1'b0, 1'b0);
		tests[6] = makeCase(iWord(opAddi), 1'b0, 1'b0, 1'b0);
		tests[7] = makeCase(iWord(opAddi), 1'b1, 1'b0, 1'b0);
		tests[8] = makeCase(iWord(opAddiu), 1'b1, 1'b0, 1'b0);
		tests[9] = makeCase(iWord(opSw), 1'b0, 1'b0, 1'b0);
		tests[10] = makeCase(iWord(opLw), 1'b0, 1'b0, 1'b0);
		tests[11] = makeCase(iWord(opBeq), 1'b0, 1'b1, 1'b0);
		tests[12] = makeCase(iWord(opBeq), 1'b0, 1'b0, 1'b0);
		tests[13] = makeCase(iWord(opBne), 1'b0, 1'b1, 1'b0);
		tests[14] = makeCase(iWord(opBne), 1'b0, 1'b0, 1'b0);
		tests[15] = makeCase(iWord(opJ), 1'b0, 1'b0, 1'b0);
		tests[16] = makeCase(iWord(opJal), 1'b0, 1'b0, 1'b0);
		tests[17] = makeCase(rWord(fnMult), 1'b0, 1'b0, 1'b0);
		tests[18] = makeCase(rWord(fnDiv), 1'b0, 1'b0, 1'b0);
		tests[19] = makeCase(rWord(fnDiv), 1'b0, 1'b0, 1'b1);
		tests[20] = makeCase(iWord(6'h3F), 1'b0, 1'b0, 1'b0);
		tests[21] = makeCase(rWord(6'h01), 1'b0, 1'b0, 1'b0);
		tests[22] = makeCase(rWord(fnMult), 1'b0, 1'b0, 1'b0);
		tests[23] = makeCase(rWord(fnDiv), 1'b0, 1'b0, 1'b0);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		wait (allDone);
		@(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule
